// ==== Makefile ====
VERILATOR ?= verilator
FILELIST ?= filelist.f
TOP ?= fm_regs_tb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failed" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
src/fm_pkg.sv
src/fm_host_port.sv
src/fm_update_fifo.sv
src/fm_slot_regs.sv
src/fm_regs_top.sv
test/fm_regs_chk.sv
test/fm_regs_tb.sv

// ==== src/fm_host_port.sv ====
// Writes while busy are dropped; channel code 3 and key-on codes 3/7 produce no update
`timescale 1ns/10ps

module fm_host_port (
	input  logic       clk,
	input  logic       rst,
	input  logic       write,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	input  logic       upd_ready,
	output logic       busy,
	output logic       lfo_en,
	output logic [2:0] lfo_freq,
	output logic [9:0] value_a,
	output logic [7:0] value_b,
	output logic       upd_valid,
	output logic [7:0] upd_reg,
	output logic [2:0] upd_ch,
	output logic [1:0] upd_op,
	output logic [7:0] upd_data,
	output logic [5:0] upd_hi
);

	logic [7:0] sel_reg;
	logic [2:0] sel_ch;
	logic [1:0] sel_op;
	logic       sel_bad;
	logic [5:0] fhi_latch;
	logic       wr_ok;
	logic       data_wr;
	logic       is_op_reg;
	logic       is_fnum_lo;
	logic       is_block_hi;
	logic       is_fb_alg;
	logic       kon_ok;
	logic [2:0] kon_ch;
	logic       req_go;

	assign wr_ok = write && !busy;
	assign data_wr = wr_ok && addr[0];

	// Register class of the current selection
	assign is_op_reg = (sel_reg[7:4] inside {fm_pkg::grp_dt_mul, fm_pkg::grp_tl,
		fm_pkg::grp_ks_ar}) && !sel_bad;
	assign is_fnum_lo = ({sel_reg[7:2], 2'b00} == fm_pkg::grp_fnum_lo) && !sel_bad;
	assign is_block_hi = ({sel_reg[7:2], 2'b00} == fm_pkg::grp_block_hi) && !sel_bad;
	assign is_fb_alg = ({sel_reg[7:2], 2'b00} == fm_pkg::grp_fb_alg) && !sel_bad;

	// Key-on carries its own channel code in the data byte
	assign kon_ok = (sel_reg == fm_pkg::reg_kon) && (din[1:0] != 2'b11);
	assign kon_ch = {1'b0, din[1:0]} + (din[2] ? 3'd3 : 3'd0);

	assign req_go = is_op_reg || is_fnum_lo || is_fb_alg || kon_ok;

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_reg <= 8'h00;
			sel_ch <= 3'd0;
			sel_op <= 2'd0;
			sel_bad <= 1'b0;
			fhi_latch <= 6'd0;
			busy <= 1'b0;
			upd_valid <= 1'b0;
			lfo_en <= 1'b0;
			lfo_freq <= 3'd0;
			value_a <= 10'd0;
			value_b <= 8'd0;
		end else if (wr_ok) begin
			busy <= 1'b1;
			if (!addr[0]) begin
				sel_reg <= din;
				sel_ch <= {1'b0, din[1:0]} + (addr[1] ? 3'd3 : 3'd0);
				// Operator order on the bus is S1, S3, S2, S4
				sel_op <= din[3:2];
				sel_bad <= din[1:0] == 2'b11;
			end else begin
				case (sel_reg)
					fm_pkg::reg_lfo: {lfo_en, lfo_freq} <= din[3:0];
					fm_pkg::reg_clka1: value_a[9:2] <= din;
					fm_pkg::reg_clka2: value_a[1:0] <= din[1:0];
					fm_pkg::reg_clkb: value_b <= din;
					default: ;
				endcase
				if (is_block_hi) begin
					fhi_latch <= din[5:0];
				end
				if (req_go) begin
					upd_valid <= 1'b1;
				end
			end
		end else if (upd_valid) begin
			// Busy covers the wait and one cycle after the handshake
			busy <= 1'b1;
			if (upd_ready) begin
				upd_valid <= 1'b0;
			end
		end else begin
			busy <= 1'b0;
		end
	end

	// Request fields, held until the FIFO takes them
	always_ff @(posedge clk) begin
		if (data_wr && req_go) begin
			upd_reg <= sel_reg;
			upd_data <= din;
			upd_hi <= fhi_latch;
			if (kon_ok) begin
				upd_ch <= kon_ch;
				upd_op <= 2'd0;
			end else begin
				upd_ch <= sel_ch;
				upd_op <= sel_op;
			end
		end
	end

endmodule

// ==== src/fm_pkg.sv ====
// Register map subset only: no timers, PCM, SSG-EG, CH3 special mode, rates beyond AR or panning
package fm_pkg;

	// Global registers, decoded straight in the host port
	localparam logic [7:0] reg_lfo = 8'h22;
	localparam logic [7:0] reg_clka1 = 8'h24;
	localparam logic [7:0] reg_clka2 = 8'h25;
	localparam logic [7:0] reg_clkb = 8'h26;

	// Key-on goes through the update queue like a channel register
	localparam logic [7:0] reg_kon = 8'h28;

	// Operator register groups, matched on the upper nibble
	localparam logic [3:0] grp_dt_mul = 4'h3;
	localparam logic [3:0] grp_tl = 4'h4;
	localparam logic [3:0] grp_ks_ar = 4'h5;

	// Channel register groups, low two bits select the channel
	localparam logic [7:0] grp_fnum_lo = 8'hA0;
	localparam logic [7:0] grp_block_hi = 8'hA4;
	localparam logic [7:0] grp_fb_alg = 8'hB0;

	// Six channels of four operators
	localparam int num_ch = 6;
	localparam int num_slots = 24;

	// Operator data byte, read as dt1/mul in group 3 and as ks/ar in group 5
	typedef union packed {
		struct packed {
			logic       rsv;
			logic [2:0] dt1;
			logic [3:0] mul;
		} dt_mul;
		struct packed {
			logic [1:0] ks;
			logic       rsv;
			logic [4:0] ar;
		} ks_ar;
	} op_data_u;

endpackage

// ==== src/fm_regs_top.sv ====
// FIFO depth sets how many updates may wait for their slot before the host sees busy stretch
`timescale 1ns/10ps

module fm_regs_top #(
	parameter int fifo_depth = 4
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        write,
	input  logic [1:0]  addr,
	input  logic [7:0]  din,
	output logic        busy,
	output logic        lfo_en,
	output logic [2:0]  lfo_freq,
	output logic [9:0]  value_a,
	output logic [7:0]  value_b,
	output logic [$clog2(fm_pkg::num_ch)-1:0] slot_ch,
	output logic [$clog2(fm_pkg::num_slots / fm_pkg::num_ch)-1:0] slot_op,
	output logic [2:0]  dt1,
	output logic [3:0]  mul,
	output logic [6:0]  tl,
	output logic [1:0]  ks,
	output logic [4:0]  ar,
	output logic [10:0] fnum,
	output logic [2:0]  block,
	output logic [2:0]  fb,
	output logic [2:0]  alg,
	output logic        keyon
);

	// Host port to FIFO
	logic       upd_valid;
	logic       upd_ready;
	logic [7:0] upd_reg;
	logic [2:0] upd_ch;
	logic [1:0] upd_op;
	logic [7:0] upd_data;
	logic [5:0] upd_hi;

	// FIFO head to slot store
	logic       q_valid;
	logic       q_ready;
	logic [7:0] q_reg;
	logic [2:0] q_ch;
	logic [1:0] q_op;
	logic [7:0] q_data;
	logic [5:0] q_hi;

	fm_host_port i_fm_host_port (
		.clk       (clk),
		.rst       (rst),
		.write     (write),
		.addr      (addr),
		.din       (din),
		.upd_ready (upd_ready),
		.busy      (busy),
		.lfo_en    (lfo_en),
		.lfo_freq  (lfo_freq),
		.value_a   (value_a),
		.value_b   (value_b),
		.upd_valid (upd_valid),
		.upd_reg   (upd_reg),
		.upd_ch    (upd_ch),
		.upd_op    (upd_op),
		.upd_data  (upd_data),
		.upd_hi    (upd_hi)
	);

	fm_update_fifo #(
		.depth (fifo_depth)
	) i_fm_update_fifo (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (upd_valid),
		.in_reg    (upd_reg),
		.in_ch     (upd_ch),
		.in_op     (upd_op),
		.in_data   (upd_data),
		.in_hi     (upd_hi),
		.in_ready  (upd_ready),
		.out_ready (q_ready),
		.out_valid (q_valid),
		.out_reg   (q_reg),
		.out_ch    (q_ch),
		.out_op    (q_op),
		.out_data  (q_data),
		.out_hi    (q_hi)
	);

	fm_slot_regs i_fm_slot_regs (
		.clk     (clk),
		.rst     (rst),
		.q_valid (q_valid),
		.q_reg   (q_reg),
		.q_ch    (q_ch),
		.q_op    (q_op),
		.q_data  (q_data),
		.q_hi    (q_hi),
		.q_ready (q_ready),
		.slot_ch (slot_ch),
		.slot_op (slot_op),
		.dt1     (dt1),
		.mul     (mul),
		.tl      (tl),
		.ks      (ks),
		.ar      (ar),
		.fnum    (fnum),
		.block   (block),
		.fb      (fb),
		.alg     (alg),
		.keyon   (keyon)
	);

endmodule

// ==== src/fm_slot_regs.sv ====
// Updates wait for their slot, up to 24 cycles each; outputs lag the slot counter by one cycle
`timescale 1ns/10ps

module fm_slot_regs (
	input  logic        clk,
	input  logic        rst,
	input  logic        q_valid,
	input  logic [7:0]  q_reg,
	input  logic [2:0]  q_ch,
	input  logic [1:0]  q_op,
	input  logic [7:0]  q_data,
	input  logic [5:0]  q_hi,
	output logic        q_ready,
	output logic [2:0]  slot_ch,
	output logic [1:0]  slot_op,
	output logic [2:0]  dt1,
	output logic [3:0]  mul,
	output logic [6:0]  tl,
	output logic [1:0]  ks,
	output logic [4:0]  ar,
	output logic [10:0] fnum,
	output logic [2:0]  block,
	output logic [2:0]  fb,
	output logic [2:0]  alg,
	output logic        keyon
);

	// Per-operator store, indexed by op * 6 + ch
	logic [2:0]  dt1_mem [fm_pkg::num_slots];
	logic [3:0]  mul_mem [fm_pkg::num_slots];
	logic [6:0]  tl_mem [fm_pkg::num_slots];
	logic [1:0]  ks_mem [fm_pkg::num_slots];
	logic [4:0]  ar_mem [fm_pkg::num_slots];
	logic        kon_mem [fm_pkg::num_slots];

	// Per-channel store
	logic [10:0] fnum_mem [fm_pkg::num_ch];
	logic [2:0]  block_mem [fm_pkg::num_ch];
	logic [2:0]  fb_mem [fm_pkg::num_ch];
	logic [2:0]  alg_mem [fm_pkg::num_ch];

	logic [4:0]       slot;
	logic [2:0]       cur_ch;
	logic [1:0]       cur_op;
	logic             is_op;
	logic [1:0]       tgt_op;
	logic [4:0]       tgt_slot;
	logic             accept;
	logic [4:0]       kon_base;
	fm_pkg::op_data_u op_word;

	assign op_word = q_data;

	// Split the slot number into operator and channel
	always_comb begin
		if (slot >= 5'(3 * fm_pkg::num_ch)) begin
			cur_op = 2'd3;
			cur_ch = 3'(slot - 5'(3 * fm_pkg::num_ch));
		end else if (slot >= 5'(2 * fm_pkg::num_ch)) begin
			cur_op = 2'd2;
			cur_ch = 3'(slot - 5'(2 * fm_pkg::num_ch));
		end else if (slot >= 5'(fm_pkg::num_ch)) begin
			cur_op = 2'd1;
			cur_ch = 3'(slot - 5'(fm_pkg::num_ch));
		end else begin
			cur_op = 2'd0;
			cur_ch = slot[2:0];
		end
	end

	// Channel registers and key-on are taken on operator 0 of the channel
	assign is_op = q_reg[7:4] inside {fm_pkg::grp_dt_mul, fm_pkg::grp_tl, fm_pkg::grp_ks_ar};
	assign tgt_op = is_op ? q_op : 2'd0;
	assign tgt_slot = 5'(tgt_op) * 5'(fm_pkg::num_ch) + 5'(q_ch);
	assign q_ready = q_valid && (slot == tgt_slot);
	assign accept = q_ready;
	assign kon_base = 5'(q_ch);

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= 5'd0;
		end else if (slot == 5'(fm_pkg::num_slots - 1)) begin
			slot <= 5'd0;
		end else begin
			slot <= slot + 5'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < fm_pkg::num_slots; i++) begin
				dt1_mem[i] <= 3'd0;
				mul_mem[i] <= 4'd0;
				tl_mem[i] <= 7'd0;
				ks_mem[i] <= 2'd0;
				ar_mem[i] <= 5'd0;
				kon_mem[i] <= 1'b0;
			end
			for (int i = 0; i < fm_pkg::num_ch; i++) begin
				fnum_mem[i] <= 11'd0;
				block_mem[i] <= 3'd0;
				fb_mem[i] <= 3'd0;
				alg_mem[i] <= 3'd0;
			end
		end else if (accept) begin
			if (q_reg[7:4] == fm_pkg::grp_dt_mul) begin
				dt1_mem[tgt_slot] <= op_word.dt_mul.dt1;
				mul_mem[tgt_slot] <= op_word.dt_mul.mul;
			end else if (q_reg[7:4] == fm_pkg::grp_tl) begin
				tl_mem[tgt_slot] <= q_data[6:0];
			end else if (q_reg[7:4] == fm_pkg::grp_ks_ar) begin
				ks_mem[tgt_slot] <= op_word.ks_ar.ks;
				ar_mem[tgt_slot] <= op_word.ks_ar.ar;
			end else if ({q_reg[7:2], 2'b00} == fm_pkg::grp_fnum_lo) begin
				fnum_mem[q_ch] <= {q_hi[2:0], q_data};
				block_mem[q_ch] <= q_hi[5:3];
			end else if ({q_reg[7:2], 2'b00} == fm_pkg::grp_fb_alg) begin
				fb_mem[q_ch] <= q_data[5:3];
				alg_mem[q_ch] <= q_data[2:0];
			end else if (q_reg == fm_pkg::reg_kon) begin
				// Bits 4..7 are S1, S2, S3, S4; slot index order is S1, S3, S2, S4
				kon_mem[kon_base] <= q_data[4];
				kon_mem[kon_base + 5'(2 * fm_pkg::num_ch)] <= q_data[5];
				kon_mem[kon_base + 5'(fm_pkg::num_ch)] <= q_data[6];
				kon_mem[kon_base + 5'(3 * fm_pkg::num_ch)] <= q_data[7];
			end
		end
	end

	// Registered view of the current slot
	always_ff @(posedge clk) begin
		if (rst) begin
			slot_ch <= 3'd0;
			slot_op <= 2'd0;
			dt1 <= 3'd0;
			mul <= 4'd0;
			tl <= 7'd0;
			ks <= 2'd0;
			ar <= 5'd0;
			fnum <= 11'd0;
			block <= 3'd0;
			fb <= 3'd0;
			alg <= 3'd0;
			keyon <= 1'b0;
		end else begin
			slot_ch <= cur_ch;
			slot_op <= cur_op;
			dt1 <= dt1_mem[slot];
			mul <= mul_mem[slot];
			tl <= tl_mem[slot];
			ks <= ks_mem[slot];
			ar <= ar_mem[slot];
			keyon <= kon_mem[slot];
			fnum <= fnum_mem[cur_ch];
			block <= block_mem[cur_ch];
			fb <= fb_mem[cur_ch];
			alg <= alg_mem[cur_ch];
		end
	end

endmodule

// ==== src/fm_update_fifo.sv ====
// Depth of 2 or more; no push while full even if a pop happens in the same cycle
`timescale 1ns/10ps

module fm_update_fifo #(
	parameter int depth = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid,
	input  logic [7:0] in_reg,
	input  logic [2:0] in_ch,
	input  logic [1:0] in_op,
	input  logic [7:0] in_data,
	input  logic [5:0] in_hi,
	output logic       in_ready,
	input  logic       out_ready,
	output logic       out_valid,
	output logic [7:0] out_reg,
	output logic [2:0] out_ch,
	output logic [1:0] out_op,
	output logic [7:0] out_data,
	output logic [5:0] out_hi
);

	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);

	// reg, ch, op, data, hi packed into one entry
	logic [26:0]   mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;
	logic          push;
	logic          pop;

	function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] p);
		if (p == aw'(depth - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign in_ready = count != cw'(depth);
	assign out_valid = count != '0;
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	assign {out_reg, out_ch, out_op, out_data, out_hi} = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= {in_reg, in_ch, in_op, in_data, in_hi};
		end
	end

endmodule

// ==== test/fm_regs_chk.sv ====
// Bound into the register top level; peeks at the internal handshake and the slot counter
`timescale 1ns/10ps

module fm_regs_chk (
	input logic       clk,
	input logic       rst,
	input logic       busy,
	input logic       upd_valid,
	input logic       upd_ready,
	input logic [26:0] upd_fields,
	input logic [4:0] slot,
	input logic       q_valid,
	input logic       q_ready
);

	// Cycles the FIFO head has waited for its slot
	logic [4:0] head_wait;

	always_ff @(posedge clk) begin
		if (rst) begin
			head_wait <= 5'd0;
		end else if (q_valid && !q_ready) begin
			head_wait <= head_wait + 5'd1;
		end else begin
			head_wait <= 5'd0;
		end
	end

	// Clean state right after reset
	a_reset_idle: assert property (@(posedge clk) $past(rst) && !rst |-> !busy && !upd_valid)
		else $error("busy or upd_valid high after reset");

	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		upd_valid && !upd_ready |=> upd_valid && $stable(upd_fields))
		else $error("update request changed before it was taken");

	a_slot_step: assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> slot == (($past(slot) == 5'd23) ? 5'd0 : $past(slot) + 5'd1))
		else $error("slot counter skipped");

	// Every target slot comes round within one full pass
	a_head_wait: assert property (@(posedge clk) disable iff (rst) head_wait < 5'd24)
		else $error("FIFO head waited longer than a full slot pass");

endmodule

bind fm_regs_top fm_regs_chk i_fm_regs_chk (
	.clk        (clk),
	.rst        (rst),
	.busy       (busy),
	.upd_valid  (upd_valid),
	.upd_ready  (upd_ready),
	.upd_fields ({upd_reg, upd_ch, upd_op, upd_data, upd_hi}),
	.slot       (i_fm_slot_regs.slot),
	.q_valid    (q_valid),
	.q_ready    (q_ready)
);

// ==== test/fm_regs_tb.sv ====
// Bus writes are never issued while busy is high; checks run only after the update queue drains
`timescale 1ns/10ps

module fm_regs_tb;

	typedef struct packed {
		fm_pkg::op_data_u dm;
		fm_pkg::op_data_u ka;
		logic [6:0]       tl;
		logic [10:0]      fnum;
		logic [2:0]       block;
		logic [2:0]       fb;
		logic [2:0]       alg;
		logic             keyon;
	} slot_exp_t;

	localparam int max_writes = 300;
	localparam int num_windows = 8;
	localparam int wd_cycles = 30 * max_writes + 100 * num_windows + 500;

	logic        clk;
	logic        rst;
	logic        write;
	logic [1:0]  addr;
	logic [7:0]  din;
	logic        busy;
	logic        lfo_en;
	logic [2:0]  lfo_freq;
	logic [9:0]  value_a;
	logic [7:0]  value_b;
	logic [2:0]  slot_ch;
	logic [1:0]  slot_op;
	logic [2:0]  dt1;
	logic [3:0]  mul;
	logic [6:0]  tl;
	logic [1:0]  ks;
	logic [4:0]  ar;
	logic [10:0] fnum;
	logic [2:0]  block;
	logic [2:0]  fb;
	logic [2:0]  alg;
	logic        keyon;

	// Reference model state
	logic [7:0]       m_sel;
	logic [2:0]       m_ch;
	logic [1:0]       m_op;
	logic             m_bad;
	logic [5:0]       m_fhi;
	fm_pkg::op_data_u m_dm [fm_pkg::num_slots];
	fm_pkg::op_data_u m_ka [fm_pkg::num_slots];
	logic [6:0]       m_tl [fm_pkg::num_slots];
	logic             m_kon [fm_pkg::num_slots];
	logic [10:0]      m_fnum [fm_pkg::num_ch];
	logic [2:0]       m_block [fm_pkg::num_ch];
	logic [2:0]       m_fb [fm_pkg::num_ch];
	logic [2:0]       m_alg [fm_pkg::num_ch];
	logic             m_lfo_en;
	logic [2:0]       m_lfo_freq;
	logic [9:0]       m_value_a;
	logic [7:0]       m_value_b;
	int               m_slot;
	int               m_out_slot;

	logic        check_on;
	int          last_wait;
	int          max_wait;
	integer      seed;
	logic [31:0] r;

	fm_regs_top #(
		.fifo_depth (4)
	) i_fm_regs_top (
		.clk (clk), .rst (rst), .write (write), .addr (addr), .din (din),
		.busy (busy), .lfo_en (lfo_en), .lfo_freq (lfo_freq),
		.value_a (value_a), .value_b (value_b),
		.slot_ch (slot_ch), .slot_op (slot_op), .dt1 (dt1), .mul (mul), .tl (tl),
		.ks (ks), .ar (ar), .fnum (fnum), .block (block), .fb (fb), .alg (alg),
		.keyon (keyon)
	);

	always #5 clk = ~clk;

	// Free-running slot scan, outputs show the slot of the previous cycle
	always @(posedge clk) begin
		if (rst) begin
			m_slot <= 0;
			m_out_slot <= 0;
		end else begin
			m_out_slot <= m_slot;
			m_slot <= (m_slot == fm_pkg::num_slots - 1) ? 0 : m_slot + 1;
		end
	end

	// Decode one bus write into the shadow registers
	function automatic void apply_write(input logic [1:0] a, input logic [7:0] d);
		int s;
		logic [2:0] kch;
		s = int'(m_op) * fm_pkg::num_ch + int'(m_ch);
		kch = {1'b0, d[1:0]} + (d[2] ? 3'd3 : 3'd0);
		if (!a[0]) begin
			m_sel = d;
			m_ch = {1'b0, d[1:0]} + (a[1] ? 3'd3 : 3'd0);
			m_op = d[3:2];
			m_bad = (d[1:0] == 2'b11);
		end else if (m_sel == fm_pkg::reg_lfo) begin
			m_lfo_en = d[3];
			m_lfo_freq = d[2:0];
		end else if (m_sel == fm_pkg::reg_clka1) begin
			m_value_a[9:2] = d;
		end else if (m_sel == fm_pkg::reg_clka2) begin
			m_value_a[1:0] = d[1:0];
		end else if (m_sel == fm_pkg::reg_clkb) begin
			m_value_b = d;
		end else if (m_sel == fm_pkg::reg_kon) begin
			if (d[1:0] != 2'b11) begin
				// Key bits S1, S2, S3, S4 land on indices 0, 2, 1, 3
				m_kon[int'(kch)] = d[4];
				m_kon[int'(kch) + 12] = d[5];
				m_kon[int'(kch) + 6] = d[6];
				m_kon[int'(kch) + 18] = d[7];
			end
		end else if (!m_bad) begin
			if (m_sel[7:4] == fm_pkg::grp_dt_mul) m_dm[s] = d;
			else if (m_sel[7:4] == fm_pkg::grp_tl) m_tl[s] = d[6:0];
			else if (m_sel[7:4] == fm_pkg::grp_ks_ar) m_ka[s] = d;
			else if ({m_sel[7:2], 2'b00} == fm_pkg::grp_block_hi) m_fhi = d[5:0];
			else if ({m_sel[7:2], 2'b00} == fm_pkg::grp_fnum_lo) begin
				m_fnum[m_ch] = {m_fhi[2:0], d};
				m_block[m_ch] = m_fhi[5:3];
			end else if ({m_sel[7:2], 2'b00} == fm_pkg::grp_fb_alg) begin
				m_fb[m_ch] = d[5:3];
				m_alg[m_ch] = d[2:0];
			end
		end
	endfunction

	function automatic slot_exp_t expected_slot(input logic [2:0] ch, input logic [1:0] op);
		slot_exp_t e;
		int s;
		s = int'(op) * fm_pkg::num_ch + int'(ch);
		e.dm = m_dm[s];
		e.dm.dt_mul.rsv = 1'b0;
		e.ka = m_ka[s];
		e.ka.ks_ar.rsv = 1'b0;
		e.tl = m_tl[s];
		e.fnum = m_fnum[ch];
		e.block = m_block[ch];
		e.fb = m_fb[ch];
		e.alg = m_alg[ch];
		e.keyon = m_kon[s];
		return e;
	endfunction

	task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic cmp_slot(input logic [2:0] gch, input logic [2:0] ech,
		input logic [1:0] gop, input logic [1:0] eop);
		if (gch !== ech) report_value("slot_ch", 32'(gch), 32'(ech));
		if (gop !== eop) report_value("slot_op", 32'(gop), 32'(eop));
	endtask

	task automatic cmp_op_data(input string name, input fm_pkg::op_data_u got,
		input fm_pkg::op_data_u exp);
		if (got !== exp) report_value(name, 32'(got), 32'(exp));
	endtask

	task automatic cmp_level(input string name, input logic [6:0] got, input logic [6:0] exp);
		if (got !== exp) report_value(name, 32'(got), 32'(exp));
	endtask

	task automatic cmp_freq(input logic [10:0] gf, input logic [10:0] ef,
		input logic [2:0] gb, input logic [2:0] eb);
		if (gf !== ef) report_value("fnum", 32'(gf), 32'(ef));
		if (gb !== eb) report_value("block", 32'(gb), 32'(eb));
	endtask

	task automatic cmp_chan(input logic [2:0] gfb, input logic [2:0] efb,
		input logic [2:0] galg, input logic [2:0] ealg);
		if (gfb !== efb) report_value("fb", 32'(gfb), 32'(efb));
		if (galg !== ealg) report_value("alg", 32'(galg), 32'(ealg));
	endtask

	task automatic cmp_bit(input string name, input logic got, input logic exp);
		if (got !== exp) report_value(name, 32'(got), 32'(exp));
	endtask

	task automatic cmp_timer(input string name, input logic [9:0] got, input logic [9:0] exp);
		if (got !== exp) report_value(name, 32'(got), 32'(exp));
	endtask

	// Slot outputs against the model, one slot per cycle
	always @(negedge clk) begin
		slot_exp_t e;
		fm_pkg::op_data_u g;
		logic [2:0] exp_ch;
		logic [1:0] exp_op;
		if (check_on) begin
			exp_ch = 3'(m_out_slot % fm_pkg::num_ch);
			exp_op = 2'(m_out_slot / fm_pkg::num_ch);
			cmp_slot(slot_ch, exp_ch, slot_op, exp_op);
			e = expected_slot(exp_ch, exp_op);
			g.dt_mul.rsv = 1'b0;
			g.dt_mul.dt1 = dt1;
			g.dt_mul.mul = mul;
			cmp_op_data("dt1/mul", g, e.dm);
			g.ks_ar.ks = ks;
			g.ks_ar.rsv = 1'b0;
			g.ks_ar.ar = ar;
			cmp_op_data("ks/ar", g, e.ka);
			cmp_level("tl", tl, e.tl);
			cmp_freq(fnum, e.fnum, block, e.block);
			cmp_chan(fb, e.fb, alg, e.alg);
			cmp_bit("keyon", keyon, e.keyon);
			cmp_bit("lfo_en", lfo_en, m_lfo_en);
			cmp_timer("lfo_freq", 10'(lfo_freq), 10'(m_lfo_freq));
			cmp_timer("value_a", value_a, m_value_a);
			cmp_timer("value_b", 10'(value_b), 10'(m_value_b));
		end
	end

	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		int waited;
		waited = 0;
		while (busy) begin
			@(posedge clk);
			#1;
			waited++;
		end
		last_wait = waited;
		write = 1'b1;
		addr = a;
		din = d;
		apply_write(a, d);
		@(posedge clk);
		#1;
		write = 1'b0;
	endtask

	// Wait for the queue to drain and the stores to come round, then one full pass
	task automatic check_window();
		while (busy || i_fm_regs_top.q_valid) begin
			@(posedge clk);
			#1;
		end
		repeat (50) @(posedge clk);
		#1;
		check_on = 1'b1;
		repeat (24) @(posedge clk);
		#1;
		check_on = 1'b0;
	endtask

	task automatic global_write(input logic [7:0] rg, input logic [7:0] d);
		bus_write(2'b00, rg);
		cmp_bit("busy", busy, 1'b1);
		@(posedge clk);
		#1;
		cmp_bit("busy", busy, 1'b0);
		bus_write(2'b01, d);
		cmp_bit("busy", busy, 1'b1);
		@(posedge clk);
		#1;
		cmp_bit("busy", busy, 1'b0);
	endtask

	initial begin
		repeat (wd_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", wd_cycles);
		$display("Test failed");
		$fatal(1);
	end

	initial begin
		logic [1:0] code;
		logic [3:0] grp;
		clk = 1'b0;
		rst = 1'b1;
		write = 1'b0;
		addr = 2'b00;
		din = 8'h00;
		check_on = 1'b0;
		seed = 15709;
		m_sel = 8'h00;
		m_ch = 3'd0;
		m_op = 2'd0;
		m_bad = 1'b0;
		m_fhi = 6'd0;
		m_lfo_en = 1'b0;
		m_lfo_freq = 3'd0;
		m_value_a = 10'd0;
		m_value_b = 8'd0;
		for (int i = 0; i < fm_pkg::num_slots; i++) begin
			m_dm[i] = 8'h00;
			m_ka[i] = 8'h00;
			m_tl[i] = 7'd0;
			m_kon[i] = 1'b0;
		end
		for (int i = 0; i < fm_pkg::num_ch; i++) begin
			m_fnum[i] = 11'd0;
			m_block[i] = 3'd0;
			m_fb[i] = 3'd0;
			m_alg[i] = 3'd0;
		end
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		check_window();

		// Global registers
		global_write(fm_pkg::reg_lfo, 8'h0D);
		global_write(fm_pkg::reg_clka1, 8'hA5);
		global_write(fm_pkg::reg_clka2, 8'h03);
		global_write(fm_pkg::reg_clkb, 8'h7E);
		cmp_bit("lfo_en", lfo_en, m_lfo_en);
		cmp_timer("value_a", value_a, m_value_a);
		check_window();

		// Random operator writes over both banks
		for (int i = 0; i < 60; i++) begin
			r = $random(seed);
			code = (r[1:0] == 2'b11) ? 2'b00 : r[1:0];
			grp = (r[5:4] == 2'd0) ? fm_pkg::grp_dt_mul :
				(r[5:4] == 2'd1) ? fm_pkg::grp_tl : fm_pkg::grp_ks_ar;
			bus_write({r[8], 1'b0}, {grp, r[3:2], code});
			bus_write({r[8], 1'b1}, r[23:16]);
		end
		check_window();

		// Frequency latch, fnum low, feedback/algorithm; code 3 is dropped
		for (int c = 0; c < 4; c++) begin
			for (int b = 0; b < 2; b++) begin
				r = $random(seed);
				bus_write({b[0], 1'b0}, fm_pkg::grp_block_hi + 8'(c));
				bus_write({b[0], 1'b1}, r[7:0]);
				bus_write({b[0], 1'b0}, fm_pkg::grp_fnum_lo + 8'(c));
				bus_write({b[0], 1'b1}, r[15:8]);
				bus_write({b[0], 1'b0}, fm_pkg::grp_fb_alg + 8'(c));
				bus_write({b[0], 1'b1}, r[23:16]);
			end
		end
		check_window();

		// Key-on with random masks and channel codes
		for (int i = 0; i < 20; i++) begin
			r = $random(seed);
			bus_write(2'b00, fm_pkg::reg_kon);
			bus_write(2'b01, {r[7:4], 1'b0, r[2:0]});
		end
		check_window();

		// Burst at one slot overruns the FIFO
		max_wait = 0;
		bus_write(2'b10, {fm_pkg::grp_tl, 2'd2, 2'd1});
		for (int i = 0; i < 10; i++) begin
			r = $random(seed);
			bus_write(2'b11, r[7:0]);
			if (last_wait > max_wait) max_wait = last_wait;
		end
		if (max_wait < 10) begin
			$display("Burst never stalled the host: longest busy wait was %0d cycles", max_wait);
			$display("Test failed");
			$fatal(1);
		end
		check_window();

		$display("Test completed successfully");
		$finish;
	end

endmodule
